/* logic/mips_pkg.sv */
package mips_pkg;

    // one fetched word, read as R, I or J format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instr_word_t;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field of OP_SPECIAL
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd9;

    // write-back source
    localparam logic [1:0] WB_ALU  = 2'd0;
    localparam logic [1:0] WB_MEM  = 2'd1;
    localparam logic [1:0] WB_LINK = 2'd2;
    localparam logic [1:0] WB_HILO = 2'd3;

    // destination register field
    localparam logic [1:0] DST_RD  = 2'd0;
    localparam logic [1:0] DST_RT  = 2'd1;
    localparam logic [1:0] DST_R31 = 2'd2;

    localparam logic [31:0] RESET_PC = 32'hBFC00000;

endpackage

/* logic/mips_ctrl_if.sv */
`timescale 1ns/1ps

interface mips_ctrl_if;

    logic [mips_pkg::ALU_OP_W-1:0] alu_op;
    // second operand source and extension
    logic       use_imm;
    logic       imm_zero_ext;
    logic       reg_write;
    logic [1:0] dst_sel;
    logic [1:0] wb_sel;
    logic       mem_read;
    logic       mem_write;
    logic       mem_byte;
    logic       load_signed;
    logic       branch_eq;
    logic       branch_ne;
    logic       jump_imm;
    logic       jump_reg;
    logic       muldiv;
    logic       mul_signed;
    // high selects HI for the move
    logic       hilo_sel;

    modport dec (
        output alu_op, use_imm, imm_zero_ext, reg_write, dst_sel, wb_sel,
               mem_read, mem_write, mem_byte, load_signed, branch_eq, branch_ne,
               jump_imm, jump_reg, muldiv, mul_signed, hilo_sel
    );

    modport uses (
        input alu_op, use_imm, imm_zero_ext, reg_write, dst_sel, wb_sel,
              mem_read, mem_write, mem_byte, load_signed, branch_eq, branch_ne,
              jump_imm, jump_reg, muldiv, mul_signed, hilo_sel
    );

endinterface

/* logic/mips_decoder.sv */
`timescale 1ns/1ps

module mips_decoder (
    input mips_pkg::instr_word_t instr,
    mips_ctrl_if.dec             ctrl
);

    // R-format ops that write rd from the ALU
    task automatic alu_reg(input logic [mips_pkg::ALU_OP_W-1:0] op);
        ctrl.alu_op = op;
        ctrl.reg_write = 1'b1;
    endtask

    always_comb begin
        // defaults give a no-op
        ctrl.alu_op = mips_pkg::ALU_ADD;
        ctrl.use_imm = 1'b0;
        ctrl.imm_zero_ext = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.dst_sel = mips_pkg::DST_RT;
        ctrl.wb_sel = mips_pkg::WB_ALU;
        ctrl.mem_read = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.mem_byte = 1'b0;
        ctrl.load_signed = 1'b0;
        ctrl.branch_eq = 1'b0;
        ctrl.branch_ne = 1'b0;
        ctrl.jump_imm = 1'b0;
        ctrl.jump_reg = 1'b0;
        ctrl.muldiv = 1'b0;
        ctrl.mul_signed = 1'b0;
        ctrl.hilo_sel = 1'b0;

        case (instr.r.opcode)
            mips_pkg::OP_SPECIAL: begin
                ctrl.dst_sel = mips_pkg::DST_RD;
                case (instr.r.funct)
                    mips_pkg::FN_SLL:  alu_reg(mips_pkg::ALU_SLL);
                    mips_pkg::FN_SRL:  alu_reg(mips_pkg::ALU_SRL);
                    mips_pkg::FN_ADDU: alu_reg(mips_pkg::ALU_ADD);
                    mips_pkg::FN_SUBU: alu_reg(mips_pkg::ALU_SUB);
                    mips_pkg::FN_AND:  alu_reg(mips_pkg::ALU_AND);
                    mips_pkg::FN_OR:   alu_reg(mips_pkg::ALU_OR);
                    mips_pkg::FN_XOR:  alu_reg(mips_pkg::ALU_XOR);
                    mips_pkg::FN_SLT:  alu_reg(mips_pkg::ALU_SLT);
                    mips_pkg::FN_SLTU: alu_reg(mips_pkg::ALU_SLTU);
                    mips_pkg::FN_JR:   ctrl.jump_reg = 1'b1;
                    mips_pkg::FN_MFHI: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.wb_sel = mips_pkg::WB_HILO;
                        ctrl.hilo_sel = 1'b1;
                    end
                    mips_pkg::FN_MFLO: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.wb_sel = mips_pkg::WB_HILO;
                    end
                    mips_pkg::FN_MULT: begin
                        ctrl.muldiv = 1'b1;
                        ctrl.mul_signed = 1'b1;
                    end
                    mips_pkg::FN_MULTU: ctrl.muldiv = 1'b1;
                    default: ;
                endcase
            end
            mips_pkg::OP_J:   ctrl.jump_imm = 1'b1;
            mips_pkg::OP_JAL: begin
                ctrl.jump_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst_sel = mips_pkg::DST_R31;
                ctrl.wb_sel = mips_pkg::WB_LINK;
            end
            mips_pkg::OP_BEQ: ctrl.branch_eq = 1'b1;
            mips_pkg::OP_BNE: ctrl.branch_ne = 1'b1;
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_LUI: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                if (instr.i.opcode == mips_pkg::OP_SLTI) begin
                    ctrl.alu_op = mips_pkg::ALU_SLT;
                end else if (instr.i.opcode == mips_pkg::OP_LUI) begin
                    ctrl.alu_op = mips_pkg::ALU_LUI;
                end
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI: begin
                ctrl.use_imm = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op = instr.i.opcode[0] ? mips_pkg::ALU_OR : mips_pkg::ALU_AND;
            end
            mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LW: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel = mips_pkg::WB_MEM;
                ctrl.mem_read = 1'b1;
                ctrl.mem_byte = (instr.i.opcode != mips_pkg::OP_LW);
                ctrl.load_signed = (instr.i.opcode == mips_pkg::OP_LB);
            end
            mips_pkg::OP_SB, mips_pkg::OP_SW: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                // sb reads the old word first
                ctrl.mem_byte = (instr.i.opcode == mips_pkg::OP_SB);
                ctrl.mem_read = (instr.i.opcode == mips_pkg::OP_SB);
            end
            default: ;
        endcase
    end

endmodule

/* logic/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic        write_enable,
    input  logic [4:0]  read_index_a,
    input  logic [4:0]  read_index_b,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    // r0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                for (int i = 1; i < 32; i++) begin
                    regs[i] <= 32'd0;
                end
            end else if (write_enable && write_index != 5'd0) begin
                regs[write_index] <= write_data;
            end
        end
    end

    assign read_data_a = (read_index_a == 5'd0) ? 32'd0 : regs[read_index_a];
    assign read_data_b = (read_index_b == 5'd0) ? 32'd0 : regs[read_index_b];

    // v0 is r2
    assign register_v0 = regs[2];

endmodule

/* logic/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::instr_word_t instr,
    mips_ctrl_if.uses             ctrl,
    input  logic [31:0]           op_a,
    input  logic [31:0]           op_b,
    output logic [31:0]           result,
    output logic [63:0]           product,
    output logic [31:0]           eff_addr,
    output logic                  take_branch
);

    logic [31:0]        imm_sext;
    logic [31:0]        imm_zext;
    logic [31:0]        operand_b;
    logic signed [63:0] product_s;
    logic [63:0]        product_u;

    assign imm_sext = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign imm_zext = {16'd0, instr.i.imm16};

    // rt unless an I-format op
    always_comb begin
        if (!ctrl.use_imm) begin
            operand_b = op_b;
        end else if (ctrl.imm_zero_ext) begin
            operand_b = imm_zext;
        end else begin
            operand_b = imm_sext;
        end
    end

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::ALU_ADD:  result = op_a + operand_b;
            mips_pkg::ALU_SUB:  result = op_a - operand_b;
            mips_pkg::ALU_AND:  result = op_a & operand_b;
            mips_pkg::ALU_OR:   result = op_a | operand_b;
            mips_pkg::ALU_XOR:  result = op_a ^ operand_b;
            mips_pkg::ALU_SLT:  result = {31'd0, $signed(op_a) < $signed(operand_b)};
            mips_pkg::ALU_SLTU: result = {31'd0, op_a < operand_b};
            // shifts act on rt by shamt
            mips_pkg::ALU_SLL:  result = operand_b << instr.r.shamt;
            mips_pkg::ALU_SRL:  result = operand_b >> instr.r.shamt;
            mips_pkg::ALU_LUI:  result = {instr.i.imm16, 16'd0};
            default:            result = 32'd0;
        endcase
    end

    // loads and stores always use a signed offset
    assign eff_addr = op_a + imm_sext;

    assign take_branch = (ctrl.branch_eq && op_a == op_b)
                      || (ctrl.branch_ne && op_a != op_b);

    // both products built, one chosen for HI/LO
    assign product_s = $signed(op_a) * $signed(op_b);
    assign product_u = {32'd0, op_a} * {32'd0, op_b};
    assign product = ctrl.mul_signed ? product_s : product_u;

endmodule

/* logic/mips_mem_access.sv */
`timescale 1ns/1ps

module mips_mem_access (
    mips_ctrl_if.uses   ctrl,
    input  logic [31:0] eff_addr,
    input  logic [31:0] store_value,
    input  logic [31:0] data_readdata,
    output logic [31:0] data_address,
    output logic [31:0] data_writedata,
    output logic [31:0] load_value
);

    logic [4:0]  lane_lsb;
    logic [7:0]  load_byte;
    logic [31:0] merged;

    assign data_address = {eff_addr[31:2], 2'b00};

    // big-endian lanes, byte 0 sits in bits 31:24
    assign lane_lsb = {~eff_addr[1:0], 3'b000};
    assign load_byte = data_readdata[lane_lsb +: 8];

    always_comb begin
        if (!ctrl.mem_byte) begin
            load_value = data_readdata;
        end else if (ctrl.load_signed) begin
            load_value = {{24{load_byte[7]}}, load_byte};
        end else begin
            load_value = {24'd0, load_byte};
        end
    end

    // sb rewrites one lane of the old word
    always_comb begin
        merged = data_readdata;
        merged[lane_lsb +: 8] = store_value[7:0];
    end

    assign data_writedata = ctrl.mem_byte ? merged : store_value;

endmodule

/* logic/mips_cpu_harvard.sv */
`timescale 1ns/1ps

module mips_cpu_harvard (
    input  logic        clk,
    input  logic        reset,
    output logic        active,
    output logic [31:0] register_v0,
    input  logic        clk_enable,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    mips_pkg::instr_word_t instr;

    // low is fetch, high is execute
    logic        state;
    logic [31:0] pc;
    logic [31:0] delay_slot;
    logic [31:0] next_delay_slot;
    logic [31:0] branch_offset;
    logic        retire;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] old_word;
    logic [31:0] mem_word;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_result;
    logic [63:0] product;
    logic [31:0] eff_addr;
    logic        take_branch;
    logic [31:0] load_value;
    logic [4:0]  wb_index;
    logic [31:0] wb_data;

    mips_ctrl_if ctrl ();

    assign instr = instr_readdata;
    assign instr_address = pc;
    assign retire = active && state;

    // sb reads only in fetch, writes in execute
    assign data_read = ctrl.mem_read && !(state && ctrl.mem_write);
    assign data_write = retire && ctrl.mem_write;

    // old word held across the sb execute cycle
    always_ff @(posedge clk) begin
        if (clk_enable && !state) begin
            old_word <= data_readdata;
        end
    end

    assign mem_word = ctrl.mem_write ? old_word : data_readdata;

    assign branch_offset = {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};

    always_comb begin
        if (take_branch) begin
            next_delay_slot = delay_slot + branch_offset;
        end else if (ctrl.jump_imm) begin
            next_delay_slot = {delay_slot[31:28], instr.j.target26, 2'b00};
        end else if (ctrl.jump_reg) begin
            next_delay_slot = rs_data;
        end else begin
            next_delay_slot = delay_slot + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                state <= 1'b0;
                pc <= mips_pkg::RESET_PC;
                delay_slot <= mips_pkg::RESET_PC + 32'd4;
                active <= 1'b1;
            end else if (active) begin
                state <= !state;
                if (state) begin
                    pc <= delay_slot;
                    delay_slot <= next_delay_slot;
                    // stop before fetching address zero
                    if (delay_slot == 32'd0) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable && retire && ctrl.muldiv) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

    always_comb begin
        case (ctrl.dst_sel)
            mips_pkg::DST_RD:  wb_index = instr.r.rd;
            mips_pkg::DST_R31: wb_index = 5'd31;
            default:           wb_index = instr.r.rt;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            mips_pkg::WB_MEM:  wb_data = load_value;
            // return address skips the delay slot
            mips_pkg::WB_LINK: wb_data = delay_slot + 32'd4;
            mips_pkg::WB_HILO: wb_data = ctrl.hilo_sel ? hi : lo;
            default:           wb_data = alu_result;
        endcase
    end

    mips_decoder decoder_i (
        .instr (instr),
        .ctrl  (ctrl.dec)
    );

    mips_regfile regfile_i (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .write_enable (retire && ctrl.reg_write),
        .read_index_a (instr.r.rs),
        .read_index_b (instr.r.rt),
        .write_index  (wb_index),
        .write_data   (wb_data),
        .read_data_a  (rs_data),
        .read_data_b  (rt_data),
        .register_v0  (register_v0)
    );

    mips_alu alu_i (
        .instr       (instr),
        .ctrl        (ctrl.uses),
        .op_a        (rs_data),
        .op_b        (rt_data),
        .result      (alu_result),
        .product     (product),
        .eff_addr    (eff_addr),
        .take_branch (take_branch)
    );

    mips_mem_access mem_access_i (
        .ctrl           (ctrl.uses),
        .eff_addr       (eff_addr),
        .store_value    (rt_data),
        .data_readdata  (mem_word),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .load_value     (load_value)
    );

endmodule

/* bench/mips_checker.sv */
`timescale 1ns/1ps

module mips_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic        active,
    input  logic        data_write,
    input  logic [31:0] data_address,
    input  logic [31:0] data_writedata,
    input  logic [31:0] instr_address,
    input  logic [31:0] register_v0,
    input  int          test_id,
    input  int          exp_stores,
    input  logic [31:0] exp_v0,
    input  logic [31:0] exp_addr,
    input  logic [31:0] exp_data,
    output int          stores_seen,
    output int          tests_done,
    output int          tests_failed,
    output int          error_count
);

    logic reset_q;
    logic active_q;
    int   test_errors;

    initial begin
        reset_q = 1'b0;
        active_q = 1'b0;
        test_errors = 0;
        stores_seen = 0;
        tests_done = 0;
        tests_failed = 0;
        error_count = 0;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    // outputs sampled at the edge, before the DUT updates
    always @(posedge clk) begin
        if (reset) begin
            stores_seen = 0;
            test_errors = 0;
        end else begin
            // first edge after reset
            if (reset_q) begin
                compare("active", 32'd1, {31'd0, active});
                compare("data_write", 32'd0, {31'd0, data_write});
                compare("instr_address", mips_pkg::RESET_PC, instr_address);
            end
            if (clk_enable && data_write) begin
                if (stores_seen < exp_stores) begin
                    compare("data_address", exp_addr, data_address);
                    compare("data_writedata", exp_data, data_writedata);
                end else begin
                    report_problem($sformatf("store to %h was not expected", data_address));
                end
                stores_seen++;
            end
            // program has ended
            if (active_q === 1'b1 && active === 1'b0) begin
                compare("register_v0", exp_v0, register_v0);
                if (stores_seen != exp_stores) begin
                    report_problem($sformatf("saw %0d stores but expected %0d",
                                             stores_seen, exp_stores));
                end
                if (test_errors == 0) begin
                    $display("test %0d passed", test_id);
                end else begin
                    $display("test %0d failed with %0d errors", test_id, test_errors);
                    tests_failed++;
                end
                error_count += test_errors;
                tests_done++;
            end
        end
        reset_q = reset;
        active_q = active;
    end

endmodule

/* bench/mips_tb.sv */
`timescale 1ns/1ps

module mips_tb;

    localparam int RESET_CYCLES = 16;
    // the memory test, rerun with stalls
    localparam int STALL_TEST = 3;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] vec [0:255];
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] imem_offset;
    int          test_start [0:7];
    int          num_tests;
    int          vec_pos;
    int          total_instr;
    int          cycle_count;
    int          cycle_limit;
    int unsigned seed;
    logic        stalling;

    int          test_id;
    int          exp_stores;
    int          store_ptr;
    logic [31:0] exp_v0;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    int          stores_seen;
    int          tests_done;
    int          tests_failed;
    int          error_count;

    mips_cpu_harvard dut_i (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    mips_checker checker_i (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .active         (active),
        .data_write     (data_write),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .instr_address  (instr_address),
        .register_v0    (register_v0),
        .test_id        (test_id),
        .exp_stores     (exp_stores),
        .exp_v0         (exp_v0),
        .exp_addr       (exp_addr),
        .exp_data       (exp_data),
        .stores_seen    (stores_seen),
        .tests_done     (tests_done),
        .tests_failed   (tests_failed),
        .error_count    (error_count)
    );

    always #10 clk = ~clk;

    // program memory starts at the reset vector
    assign imem_offset = instr_address - mips_pkg::RESET_PC;
    assign instr_readdata = (imem_offset < 32'd256) ? imem[imem_offset[7:2]] : 32'd0;

    // data memory answers only while data_read is high
    assign data_readdata = data_read ? dmem[data_address[7:2]] : 32'hdeadbeef;

    always @(posedge clk) begin
        if (clk_enable && data_write) begin
            dmem[data_address[7:2]] <= data_writedata;
        end
    end

    // next expected store pair
    assign exp_addr = vec[store_ptr + 2 * stores_seen];
    assign exp_data = vec[store_ptr + 2 * stores_seen + 1];

    task automatic run_test(input int k, input int label);
        int p;
        int n_instr;
        int n_data;
        int done_before;
        p = test_start[k];
        n_instr = vec[p];
        n_data = vec[p + 1];
        @(posedge clk);
        #2;
        reset = 1'b1;
        clk_enable = 1'b1;
        test_id = label;
        exp_stores = vec[p + 2];
        exp_v0 = vec[p + 3];
        store_ptr = p + 4 + n_instr + n_data;
        for (int a = 0; a < 64; a++) begin
            imem[a] = (a < n_instr) ? vec[p + 4 + a] : 32'd0;
            dmem[a] = (a < n_data) ? vec[p + 4 + n_instr + a] : 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        done_before = tests_done;
        while (tests_done == done_before) begin
            @(posedge clk);
            #2;
            if (stalling) begin
                clk_enable = ($urandom % 2) == 0;
            end
        end
        clk_enable = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        clk_enable = 1'b1;
        stalling = 1'b0;
        test_id = 0;
        exp_stores = 0;
        exp_v0 = 32'd0;
        store_ptr = 0;
        seed = 32'h9e002777;
        void'($urandom(seed));
        $readmemh("bench/mips_vectors.txt", vec);
        num_tests = vec[0];
        vec_pos = 1;
        total_instr = 0;
        for (int k = 0; k < num_tests; k++) begin
            test_start[k] = vec_pos;
            total_instr += vec[vec_pos];
            vec_pos += 4 + vec[vec_pos] + vec[vec_pos + 1] + 2 * vec[vec_pos + 2];
        end
        total_instr += vec[test_start[STALL_TEST]];
        // two cycles per instruction, four times over for stalls
        cycle_limit = total_instr * 2 * 4 + (num_tests + 1) * RESET_CYCLES + 200;
        for (int k = 0; k < num_tests; k++) begin
            run_test(k, k + 1);
        end
        stalling = 1'b1;
        run_test(STALL_TEST, num_tests + 1);
        $display("%0d tests run, %0d failed, %0d errors", tests_done, tests_failed, error_count);
        if (error_count == 0 && tests_done == num_tests + 1) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the programs did not finish within %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* project.f */
logic/mips_pkg.sv
logic/mips_ctrl_if.sv
logic/mips_decoder.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_mem_access.sv
logic/mips_cpu_harvard.sv
bench/mips_checker.sv
bench/mips_tb.sv

/* bench/mips_vectors.txt */
// first word is the test count; each test then has a header of instruction count,
// data word count, store count and final v0, then instructions, data words, store address/data
4
// test 1: alu ops, shifts, compares and lui
16 00 00 0012a550
3c081234 35085678 2409fff0 01095021 // lui ori addiu addu
01095823 014b6026 000c6100 00086a02 // subu xor sll srl
0128702a 0109782b 2930fff1 3111ff0f // slt sltu slti andi
018d1025 00511021 000e7200 004e1021 // or addu sll addu
00501021 000f7b00 004f1021 00491024 // addu sll addu and
00000008 00000000                   // jr $0 and its slot
// test 2: mult and multu with hi/lo moves
0e 00 00 fff9ffff
2408fffd 24090007 01090018 00005010 // addiu addiu mult mfhi
00005812 01090019 00006010 000c6400 // mflo multu mfhi sll
016c1026 004a1021 00006812 004d1023 // xor addu mflo subu
00000008 00000000
// test 3: branches and jumps, slots always run
17 00 00 bfc000bb
24080005 24090005 11090003 24020001 // beq taken
24420100 24420200 15090002 24420002 // skipped pair, bne not taken
15000002 24420004 24420400 11000001 // bne taken, beq not taken
24420008 0ff00011 24420010 0bf00014 // jal to +44, j to +50
24420020 001f5021 03e00008 24420040 // subroutine copies ra, jr ra
004a1021 00000008 00000000
// test 4: word and byte loads and stores
15 02 05 000c7f73
8c080004 ac080010 8c090010 800a0000 // lw sw lw lb
900b0001 800c0002 900d0003 800e0001 // lbu lb lbu lb
a00b0005 a00d0013 8c0f0004 012f1026 // sb sb lw xor
004a1021 004b1021 000c6200 004c1021 // addu addu sll addu
004d1021 ac0e0014 a00c0016 00000008 // addu sw sb jr
00000000
80f27f01 cafef00d
00000010 cafef00d
00000004 caf2f00d
00000010 cafef001
00000014 fffffff2
00000014 ffff00f2
